//--- src/mci_axi_sub_pkg.sv
// Bus widths, address map, request and response structs, state and target enums
package mci_axi_sub_pkg;

    // Bus widths
    localparam int addr_w = 32;
    localparam int data_w = 32;
    localparam int user_w = 32;
    localparam int id_w   = 8;
    localparam int strb_w = data_w / 8;
    // SRAM wait state field
    localparam int wait_w = 4;

    // Register window, 4 KB at the bottom of the map
    localparam logic [addr_w-1:0] reg_base  = 32'h0000_0000;
    localparam logic [addr_w-1:0] reg_span  = 32'h0000_1000;
    // Bank select and register index bits
    localparam int priv_bank_bit = 11;
    localparam int reg_idx_lsb   = 2;
    localparam int reg_idx_w     = 3;
    localparam int num_regs      = 2 ** reg_idx_w;
    // SRAM window, span set by SRAM_DEPTH
    localparam logic [addr_w-1:0] sram_base = 32'h0001_0000;

    typedef struct packed {
        logic [addr_w-1:0] addr;
        logic [user_w-1:0] user;
        logic [id_w-1:0]   id;
        logic [data_w-1:0] wdata;
        logic [strb_w-1:0] wstrb;
    } axi_wr_req_t;

    typedef struct packed {
        logic [addr_w-1:0] addr;
        logic [user_w-1:0] user;
        logic [id_w-1:0]   id;
    } axi_rd_req_t;

    typedef struct packed {
        logic [id_w-1:0] id;
        logic            err;
    } axi_wr_resp_t;

    typedef struct packed {
        logic [id_w-1:0]   id;
        logic [data_w-1:0] rdata;
        logic              err;
    } axi_rd_resp_t;

    // Internal simplex request
    typedef struct packed {
        logic [addr_w-1:0] addr;
        logic              write;
        logic [user_w-1:0] user;
        logic [id_w-1:0]   id;
        logic [data_w-1:0] wdata;
        logic [strb_w-1:0] wstrb;
    } cif_req_t;

    typedef struct packed {
        logic [data_w-1:0] rdata;
        logic              hold;
        logic              err;
    } cif_resp_t;

    typedef enum logic [1:0] {S_IDLE, S_ACCESS, S_RESP} sub_state_t;
    typedef enum logic [1:0] {TGT_REG, TGT_SRAM, TGT_NONE} tgt_sel_t;

endpackage

//--- src/mci_axi_sub_fsm.sv
// Request sequencer from the AXI-style write and read ports to the internal request
module mci_axi_sub_fsm (
    input  logic                          clk,
    input  logic                          rst_n,
    input  logic                          wr_valid,
    input  mci_axi_sub_pkg::axi_wr_req_t  wr_req,
    output logic                          wr_ready,
    output logic                          wr_resp_valid,
    output mci_axi_sub_pkg::axi_wr_resp_t wr_resp,
    input  logic                          rd_valid,
    input  mci_axi_sub_pkg::axi_rd_req_t  rd_req,
    output logic                          rd_ready,
    output logic                          rd_resp_valid,
    output mci_axi_sub_pkg::axi_rd_resp_t rd_resp,
    output logic                          dv,
    output mci_axi_sub_pkg::cif_req_t     cif_req,
    input  mci_axi_sub_pkg::cif_resp_t    cif_resp,
    input  logic                          expired
);
    import mci_axi_sub_pkg::*;

    sub_state_t        state;
    logic              is_write;
    logic              wr_accept;
    logic              rd_accept;
    logic              done;
    logic              resp_err;
    logic [data_w-1:0] resp_rdata;

    // Write wins over a read in the same cycle
    assign wr_accept = (state == S_IDLE) && wr_valid;
    assign rd_accept = (state == S_IDLE) && rd_valid && !wr_valid;
    // Target released the request, or the timer gave up on it
    assign done = (state == S_ACCESS) && (!cif_resp.hold || expired);

    // Only back-pressure toward the initiator
    assign wr_ready = (state == S_IDLE);
    assign rd_ready = (state == S_IDLE) && !wr_valid;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state         <= S_IDLE;
            dv            <= 1'b0;
            is_write      <= 1'b0;
            wr_resp_valid <= 1'b0;
            rd_resp_valid <= 1'b0;
        end else begin
            // Strobes last one cycle
            wr_resp_valid <= 1'b0;
            rd_resp_valid <= 1'b0;
            unique case (state)
                S_IDLE: begin
                    if (wr_accept || rd_accept) begin
                        state    <= S_ACCESS;
                        dv       <= 1'b1;
                        is_write <= wr_accept;
                    end
                end
                S_ACCESS: begin
                    if (done) begin
                        state         <= S_RESP;
                        dv            <= 1'b0;
                        wr_resp_valid <= is_write;
                        rd_resp_valid <= !is_write;
                    end
                end
                // One turnaround cycle before ready again
                S_RESP:  state <= S_IDLE;
                default: state <= S_IDLE;
            endcase
        end
    end

    // Captured request and completion payload
    always_ff @(posedge clk) begin
        if (wr_accept) begin
            cif_req <= '{addr: wr_req.addr, write: 1'b1, user: wr_req.user, id: wr_req.id,
                         wdata: wr_req.wdata, wstrb: wr_req.wstrb};
        end else if (rd_accept) begin
            cif_req <= '{addr: rd_req.addr, write: 1'b0, user: rd_req.user, id: rd_req.id,
                         wdata: '0, wstrb: '0};
        end
        if (done) begin
            // Hold still high means timeout
            resp_err   <= cif_resp.hold ? 1'b1 : cif_resp.err;
            resp_rdata <= cif_resp.hold ? '0 : cif_resp.rdata;
        end
    end

    assign wr_resp = '{id: cif_req.id, err: resp_err};
    assign rd_resp = '{id: cif_req.id, rdata: resp_rdata, err: resp_err};

    // Targets see a steady request for the whole held access
    a_req_stable: assert property (@(posedge clk) disable iff (!rst_n)
        dv && cif_resp.hold |=> $stable(cif_req));

endmodule

//--- src/mci_access_timer.sv
// Access timer that counts held request cycles and flags a timeout
module mci_access_timer #(
    parameter int TIMEOUT_CYCLES = 8
) (
    input  logic clk,
    input  logic rst_n,
    input  logic dv,
    input  logic hold,
    output logic expired
);
    localparam int cnt_w = $clog2(TIMEOUT_CYCLES + 1);

    logic [cnt_w-1:0] cnt;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            cnt     <= '0;
            expired <= 1'b0;
        end else if (!dv) begin
            cnt     <= '0;
            expired <= 1'b0;
        end else begin
            // Saturates at the limit so expired pulses once
            if (hold && cnt != cnt_w'(TIMEOUT_CYCLES)) begin
                cnt <= cnt + 1'b1;
            end
            expired <= hold && (cnt == cnt_w'(TIMEOUT_CYCLES - 1));
        end
    end

    // Sequencer drops dv on the expiry cycle, not before
    a_exp_dv: assert property (@(posedge clk) disable iff (!rst_n) expired |-> dv);

endmodule

//--- src/mci_axi_sub_decode.sv
// Address decode, privilege check, target steering and response mux
module mci_axi_sub_decode #(
    parameter int SRAM_DEPTH = 256
) (
    input  logic                                dv,
    input  mci_axi_sub_pkg::cif_req_t           cif_req,
    output mci_axi_sub_pkg::cif_resp_t          cif_resp,
    output logic                                reg_dv,
    input  mci_axi_sub_pkg::cif_resp_t          reg_resp,
    output logic                                sram_dv,
    input  mci_axi_sub_pkg::cif_resp_t          sram_resp,
    output logic                                priv_ok,
    output logic                                debug_req,
    output logic                                cptra_req,
    input  logic [mci_axi_sub_pkg::user_w-1:0]  strap_debug_axi_user,
    input  logic [mci_axi_sub_pkg::user_w-1:0]  strap_cptra_axi_user
);
    import mci_axi_sub_pkg::*;

    // First byte past the SRAM window
    localparam logic [addr_w-1:0] sram_end = sram_base + addr_w'(SRAM_DEPTH * 4);

    tgt_sel_t tgt;
    logic     debug_user;
    logic     cptra_user;
    logic     priv_bank;
    logic     deny;

    // Address classification
    always_comb begin
        if ((cif_req.addr - reg_base) < reg_span) begin
            tgt = TGT_REG;
        end else if (cif_req.addr >= sram_base && cif_req.addr < sram_end) begin
            tgt = TGT_SRAM;
        end else begin
            tgt = TGT_NONE;
        end
    end

    // Strap user matches
    assign debug_user = (cif_req.user == strap_debug_axi_user);
    assign cptra_user = (cif_req.user == strap_cptra_axi_user);
    assign priv_ok    = debug_user || cptra_user;
    assign debug_req  = dv && debug_user;
    assign cptra_req  = dv && cptra_user;

    // Privileged bank needs a strap user
    assign priv_bank = (tgt == TGT_REG) && cif_req.addr[priv_bank_bit];
    assign deny      = (tgt == TGT_NONE) || (priv_bank && !priv_ok);

    // Denied requests never reach a target
    assign reg_dv  = dv && !deny && (tgt == TGT_REG);
    assign sram_dv = dv && !deny && (tgt == TGT_SRAM);

    // Error path answers at once with zero data
    always_comb begin
        if (deny) begin
            cif_resp = '{rdata: '0, hold: 1'b0, err: 1'b1};
        end else if (tgt == TGT_SRAM) begin
            cif_resp = sram_resp;
        end else begin
            cif_resp = reg_resp;
        end
    end

    // One target at a time
    always_comb begin
        a_one_target: assert final (!(reg_dv && sram_dv));
    end

endmodule

//--- src/mci_reg_block.sv
// General and privileged register banks with the SRAM wait state field
module mci_reg_block (
    input  logic                               clk,
    input  logic                               rst_n,
    input  logic                               reg_dv,
    input  mci_axi_sub_pkg::cif_req_t          cif_req,
    output mci_axi_sub_pkg::cif_resp_t         reg_resp,
    output logic [mci_axi_sub_pkg::wait_w-1:0] sram_wait
);
    import mci_axi_sub_pkg::*;

    // Bank 0 general, bank 1 privileged
    logic [1:0][num_regs-1:0][data_w-1:0] banks;
    logic                                 bank;
    logic [reg_idx_w-1:0]                 idx;

    assign bank = cif_req.addr[priv_bank_bit];
    assign idx  = cif_req.addr[reg_idx_lsb +: reg_idx_w];

    // Byte lanes written only where strobed
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            banks <= '0;
        end else if (reg_dv && cif_req.write) begin
            for (int b = 0; b < strb_w; b++) begin
                if (cif_req.wstrb[b]) begin
                    banks[bank][idx][8*b +: 8] <= cif_req.wdata[8*b +: 8];
                end
            end
        end
    end

    // Registers never stall
    assign reg_resp = '{rdata: banks[bank][idx], hold: 1'b0, err: 1'b0};

    // General register 0 low nibble
    assign sram_wait = banks[0][0][wait_w-1:0];

endmodule

//--- src/mci_sram_block.sv
// Word SRAM with byte strobes and a configurable number of wait states
module mci_sram_block #(
    parameter int SRAM_DEPTH = 256
) (
    input  logic                               clk,
    input  logic                               rst_n,
    input  logic                               sram_dv,
    input  mci_axi_sub_pkg::cif_req_t          cif_req,
    input  logic [mci_axi_sub_pkg::wait_w-1:0] sram_wait,
    output mci_axi_sub_pkg::cif_resp_t         sram_resp
);
    import mci_axi_sub_pkg::*;

    localparam int idx_w = $clog2(SRAM_DEPTH);

    logic [data_w-1:0] mem [SRAM_DEPTH];
    logic [wait_w-1:0] wait_cnt;
    logic [idx_w-1:0]  idx;
    logic              last;

    // Word index from byte address
    assign idx  = cif_req.addr[idx_w+1:2];
    // Final cycle of the access
    assign last = sram_dv && (wait_cnt == sram_wait);

    assign sram_resp = '{rdata: mem[idx], hold: sram_dv && !last, err: 1'b0};

    // Wait counter, dropped access clears it
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wait_cnt <= '0;
        end else if (sram_dv && !last) begin
            wait_cnt <= wait_cnt + 1'b1;
        end else begin
            wait_cnt <= '0;
        end
    end

    // Write lands only in the final cycle
    always_ff @(posedge clk) begin
        if (last && cif_req.write) begin
            for (int b = 0; b < strb_w; b++) begin
                if (cif_req.wstrb[b]) begin
                    mem[idx][8*b +: 8] <= cif_req.wdata[8*b +: 8];
                end
            end
        end
    end

    // Counter never runs past the configured wait during an access
    a_cnt_bound: assert property (@(posedge clk) disable iff (!rst_n)
        sram_dv |-> wait_cnt <= sram_wait);

endmodule

//--- src/mci_axi_sub_top.sv
// Top level with sequencer, access timer, decoder, register block and SRAM
module mci_axi_sub_top #(
    parameter int SRAM_DEPTH     = 256,
    parameter int TIMEOUT_CYCLES = 8
) (
    input  logic                               clk,
    input  logic                               rst_n,
    input  logic                               wr_valid,
    input  mci_axi_sub_pkg::axi_wr_req_t       wr_req,
    output logic                               wr_ready,
    output logic                               wr_resp_valid,
    output mci_axi_sub_pkg::axi_wr_resp_t      wr_resp,
    input  logic                               rd_valid,
    input  mci_axi_sub_pkg::axi_rd_req_t       rd_req,
    output logic                               rd_ready,
    output logic                               rd_resp_valid,
    output mci_axi_sub_pkg::axi_rd_resp_t      rd_resp,
    output logic                               debug_req,
    output logic                               cptra_req,
    input  logic [mci_axi_sub_pkg::user_w-1:0] strap_debug_axi_user,
    input  logic [mci_axi_sub_pkg::user_w-1:0] strap_cptra_axi_user
);
    import mci_axi_sub_pkg::*;

    // Internal request between sequencer and decoder
    logic              dv;
    cif_req_t          cif_req;
    cif_resp_t         cif_resp;
    logic              expired;
    // Target side
    logic              reg_dv;
    logic              sram_dv;
    cif_resp_t         reg_resp;
    cif_resp_t         sram_resp;
    logic [wait_w-1:0] sram_wait;

    mci_axi_sub_fsm i_mci_axi_sub_fsm (
        .clk, .rst_n, .wr_valid, .wr_req, .wr_ready, .wr_resp_valid, .wr_resp,
        .rd_valid, .rd_req, .rd_ready, .rd_resp_valid, .rd_resp,
        .dv, .cif_req, .cif_resp, .expired
    );

    mci_access_timer #(.TIMEOUT_CYCLES(TIMEOUT_CYCLES)) i_mci_access_timer (
        .clk, .rst_n, .dv, .hold(cif_resp.hold), .expired
    );

    // Privilege result kept internal to the decoder
    mci_axi_sub_decode #(.SRAM_DEPTH(SRAM_DEPTH)) i_mci_axi_sub_decode (
        .dv, .cif_req, .cif_resp, .reg_dv, .reg_resp, .sram_dv, .sram_resp,
        .priv_ok(), .debug_req, .cptra_req, .strap_debug_axi_user, .strap_cptra_axi_user
    );

    mci_reg_block i_mci_reg_block (
        .clk, .rst_n, .reg_dv, .cif_req, .reg_resp, .sram_wait
    );

    mci_sram_block #(.SRAM_DEPTH(SRAM_DEPTH)) i_mci_sram_block (
        .clk, .rst_n, .sram_dv, .cif_req, .sram_wait, .sram_resp
    );

endmodule

//--- sim/tb_clock_gen.sv
// Free-running testbench clock with a 100 ns period
module tb_clock_gen (
    output logic clk
);
    timeunit 1ns;
    timeprecision 100ps;

    // Half of the 100 ns period
    localparam time half_period = 50ns;

    initial begin
        clk = 1'b0;
        forever #(half_period) clk = ~clk;
    end

endmodule

//--- sim/tb_mci_axi_sub_top.sv
// Directed tests, LCG data source, compare tasks and DUT instance for the AXI-style subordinate
module tb_mci_axi_sub_top;
    timeunit 1ns;
    timeprecision 100ps;
    import mci_axi_sub_pkg::*;

    // Users seen on the bus
    localparam logic [user_w-1:0] dbg_user   = 32'hDEB0_0001;
    localparam logic [user_w-1:0] cptra_user = 32'hCA11_0002;
    localparam logic [user_w-1:0] gen_user   = 32'h0000_1234;
    localparam logic [user_w-1:0] bad_user   = 32'h0BAD_0BAD;
    localparam int                wait_limit = 50;

    logic              clk;
    logic              rst_n;
    logic              wr_valid;
    axi_wr_req_t       wr_req;
    logic              wr_ready;
    logic              wr_resp_valid;
    axi_wr_resp_t      wr_resp;
    logic              rd_valid;
    axi_rd_req_t       rd_req;
    logic              rd_ready;
    logic              rd_resp_valid;
    axi_rd_resp_t      rd_resp;
    logic              debug_req;
    logic              cptra_req;
    logic [user_w-1:0] strap_debug_axi_user;
    logic [user_w-1:0] strap_cptra_axi_user;
    // Testbench state
    logic [31:0]       lcg_state;
    logic [id_w-1:0]   txn_id;
    logic              debug_seen;
    logic              cptra_seen;

    tb_clock_gen i_tb_clock_gen (.clk);

    mci_axi_sub_top #(.SRAM_DEPTH(256), .TIMEOUT_CYCLES(8)) i_mci_axi_sub_top (
        .clk, .rst_n, .wr_valid, .wr_req, .wr_ready, .wr_resp_valid, .wr_resp,
        .rd_valid, .rd_req, .rd_ready, .rd_resp_valid, .rd_resp,
        .debug_req, .cptra_req, .strap_debug_axi_user, .strap_cptra_axi_user
    );

    // Privilege strobes latched between falling edges
    always @(negedge clk) begin
        if (debug_req) debug_seen = 1'b1;
        if (cptra_req) cptra_seen = 1'b1;
    end

    // Numerical Recipes constants
    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    // Strobed bytes replace old ones
    function automatic logic [31:0] merge_bytes(input logic [31:0] old_word,
                                                input logic [31:0] data, input logic [3:0] strb);
        logic [31:0] res;
        res = old_word;
        for (int b = 0; b < 4; b++) begin
            if (strb[b]) res[8*b +: 8] = data[8*b +: 8];
        end
        return res;
    endfunction

    task automatic stop_on_error(input string what);
        $display("%s", what);
        $display("Errors found");
        $fatal(1);
    endtask

    task automatic check_wr_resp(input string name, input axi_wr_resp_t got,
                                 input axi_wr_resp_t want);
        if (got !== want) stop_on_error($sformatf("Mismatch %s got %h expected %h", name, got, want));
    endtask

    task automatic check_rd_resp(input string name, input axi_rd_resp_t got,
                                 input axi_rd_resp_t want);
        if (got !== want) stop_on_error($sformatf("Mismatch %s got %h expected %h", name, got, want));
    endtask

    task automatic check_bit(input string name, input logic got, input logic want);
        if (got !== want) stop_on_error($sformatf("Mismatch %s got %h expected %h", name, got, want));
    endtask

    // Called on a falling edge, returns on the falling edge of the strobe
    task automatic do_write(input logic [31:0] addr, input logic [31:0] user,
                            input logic [31:0] data, input logic [3:0] strb, input logic want_err);
        int cycles;
        cycles = 0;
        wr_req = '{addr: addr, user: user, id: txn_id, wdata: data, wstrb: strb};
        wr_valid = 1'b1;
        while (!wr_ready) begin
            @(negedge clk);
            cycles++;
            if (cycles > wait_limit) stop_on_error("Timeout while waiting for write ready");
        end
        // Accepted on the next rising edge
        @(negedge clk);
        wr_valid = 1'b0;
        cycles = 0;
        while (!wr_resp_valid) begin
            @(negedge clk);
            cycles++;
            if (cycles > wait_limit) stop_on_error("Timeout while waiting for write response");
        end
        check_wr_resp("wr_resp", wr_resp, '{id: txn_id, err: want_err});
        txn_id++;
    endtask

    task automatic do_read(input logic [31:0] addr, input logic [31:0] user,
                           input logic [31:0] want_data, input logic want_err);
        int cycles;
        cycles = 0;
        rd_req = '{addr: addr, user: user, id: txn_id};
        rd_valid = 1'b1;
        while (!rd_ready) begin
            @(negedge clk);
            cycles++;
            if (cycles > wait_limit) stop_on_error("Timeout while waiting for read ready");
        end
        @(negedge clk);
        rd_valid = 1'b0;
        cycles = 0;
        while (!rd_resp_valid) begin
            @(negedge clk);
            cycles++;
            if (cycles > wait_limit) stop_on_error("Timeout while waiting for read response");
        end
        check_rd_resp("rd_resp", rd_resp, '{id: txn_id, rdata: want_data, err: want_err});
        txn_id++;
    endtask

    task automatic test_reset();
        check_bit("wr_ready", wr_ready, 1'b1);
        check_bit("rd_ready", rd_ready, 1'b1);
        check_bit("debug_req", debug_req, 1'b0);
        check_bit("cptra_req", cptra_req, 1'b0);
        // Idle bus gives no strobes
        repeat (3) begin
            @(negedge clk);
            check_bit("wr_resp_valid", wr_resp_valid, 1'b0);
            check_bit("rd_resp_valid", rd_resp_valid, 1'b0);
        end
        for (int i = 0; i < 8; i++) do_read(32'(i * 4), gen_user, '0, 1'b0);
    endtask

    task automatic test_gen_regs();
        logic [31:0] want;
        logic [31:0] data;
        // General register 3
        want = 32'h1122_3344;
        do_write(32'h0C, gen_user, want, 4'hF, 1'b0);
        data = lcg_next();
        want = merge_bytes(want, data, 4'b0101);
        do_write(32'h0C, gen_user, data, 4'b0101, 1'b0);
        do_read(32'h0C, gen_user, want, 1'b0);
        data = lcg_next();
        want = merge_bytes(want, data, 4'b1000);
        do_write(32'h0C, gen_user, data, 4'b1000, 1'b0);
        do_read(32'h0C, gen_user, want, 1'b0);
    endtask

    task automatic test_priv();
        logic [31:0] data;
        data = lcg_next();
        // Privileged register 5
        debug_seen = 1'b0;
        do_write(32'h814, dbg_user, data, 4'hF, 1'b0);
        check_bit("debug_req", debug_seen, 1'b1);
        do_read(32'h814, dbg_user, data, 1'b0);
        do_write(32'h814, bad_user, ~data, 4'hF, 1'b1);
        do_read(32'h814, dbg_user, data, 1'b0);
        do_read(32'h814, bad_user, '0, 1'b1);
        cptra_seen = 1'b0;
        do_read(32'h814, cptra_user, data, 1'b0);
        check_bit("cptra_req", cptra_seen, 1'b1);
    endtask

    task automatic test_sram();
        logic [31:0] addrs [4];
        logic [31:0] want [4];
        logic [31:0] data;
        addrs = '{32'h0001_0000, 32'h0001_0040, 32'h0001_0104, 32'h0001_03FC};
        // Two wait states
        do_write(32'h0, gen_user, 32'h2, 4'hF, 1'b0);
        for (int i = 0; i < 4; i++) begin
            want[i] = lcg_next();
            do_write(addrs[i], gen_user, want[i], 4'hF, 1'b0);
        end
        for (int i = 0; i < 4; i++) do_read(addrs[i], gen_user, want[i], 1'b0);
        data = lcg_next();
        want[1] = merge_bytes(want[1], data, 4'b0110);
        do_write(addrs[1], gen_user, data, 4'b0110, 1'b0);
        do_read(addrs[1], gen_user, want[1], 1'b0);
    endtask

    task automatic test_decode();
        // Gap above the register window, then just past the last SRAM word
        do_write(32'h0000_2000, gen_user, lcg_next(), 4'hF, 1'b1);
        do_read(32'h0000_2000, gen_user, '0, 1'b1);
        do_write(32'h0001_0400, gen_user, lcg_next(), 4'hF, 1'b1);
        do_read(32'h0001_0400, gen_user, '0, 1'b1);
    endtask

    task automatic test_timeout();
        logic [31:0] keep;
        logic [31:0] data;
        keep = lcg_next();
        do_write(32'h0, gen_user, 32'h0, 4'hF, 1'b0);
        do_write(32'h0001_0080, gen_user, keep, 4'hF, 1'b0);
        // 15 waits outlast the 8 cycle timer
        do_write(32'h0, gen_user, 32'hF, 4'hF, 1'b0);
        do_write(32'h0001_0080, gen_user, ~keep, 4'hF, 1'b1);
        do_write(32'h0, gen_user, 32'h0, 4'hF, 1'b0);
        do_read(32'h0001_0080, gen_user, keep, 1'b0);
        data = lcg_next();
        do_write(32'h0001_0080, gen_user, data, 4'hF, 1'b0);
        do_read(32'h0001_0080, gen_user, data, 1'b0);
    endtask

    initial begin
        lcg_state            = 32'd6188;
        txn_id               = '0;
        debug_seen           = 1'b0;
        cptra_seen           = 1'b0;
        rst_n                = 1'b0;
        wr_valid             = 1'b0;
        rd_valid             = 1'b0;
        wr_req               = '0;
        rd_req               = '0;
        strap_debug_axi_user = dbg_user;
        strap_cptra_axi_user = cptra_user;
        repeat (16) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
        @(negedge clk);
        test_reset();
        test_gen_regs();
        test_priv();
        test_sram();
        test_decode();
        test_timeout();
        $display("No errors");
        $finish;
    end

endmodule

//--- vlog.f
src/mci_axi_sub_pkg.sv
src/mci_axi_sub_fsm.sv
src/mci_access_timer.sv
src/mci_axi_sub_decode.sv
src/mci_reg_block.sv
src/mci_sram_block.sv
src/mci_axi_sub_top.sv
sim/tb_clock_gen.sv
sim/tb_mci_axi_sub_top.sv
